/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core_bus
FLAGS     ?= --assert
FILELIST  ?= core_bus.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --top-module $(TOP) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the binary is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* axi_lane_adapter.sv */
`timescale 1ns/1ns
`include "bus_consts.svh"

module axi_lane_adapter (
  input  bus_pkg::bus_req_t   cur_req_i,
  output bus_pkg::addr_t      araddr_o,
  output logic [2:0]          arsize_o,
  output bus_pkg::addr_t      awaddr_o,
  output logic [2:0]          awsize_o,
  output bus_pkg::beat_t      wdata_o,
  output bus_pkg::beat_strb_t wstrb_o,
  input  bus_pkg::beat_t      rdata_i,
  output bus_pkg::word_t      rdata_o
);
  import bus_pkg::*;

  logic [2:0] size;
  logic [1:0] offs;
  word_t      wdata_sh;
  strb_t      strb_sh;
  logic       hi_lane;

  assign offs    = cur_req_i.addr[1:0];
  assign hi_lane = cur_req_i.addr[2];

  // size follows the byte mask
  always_comb
  begin
    case (cur_req_i.strb)
      4'h1:    size = `BUS_SIZE_B;
      4'h3:    size = `BUS_SIZE_H;
      4'hf:    size = `BUS_SIZE_W;
      default: size = `BUS_SIZE_B;
    endcase
  end

  assign araddr_o = cur_req_i.addr;
  assign awaddr_o = cur_req_i.addr;
  assign arsize_o = size;
  assign awsize_o = size;

  assign wdata_sh = cur_req_i.wdata << {offs, 3'b000};
  assign strb_sh  = cur_req_i.strb << offs;

  assign wdata_o = {wdata_sh, wdata_sh};  // same word on both lanes
  assign wstrb_o = hi_lane ? {strb_sh, 4'h0} : {4'h0, strb_sh};

  // caller shifts the bytes down itself
  assign rdata_o = hi_lane ? rdata_i[63:32] : rdata_i[31:0];

endmodule

/* bus_consts.svh */
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// mtime halves in the clint window
`define BUS_RTC_ADDR    32'h0200_bff8
`define BUS_RTC_ADDR_UP 32'h0200_bffc

// axi size codes, bytes per beat as log2
`define BUS_SIZE_B 3'd0
`define BUS_SIZE_H 3'd1
`define BUS_SIZE_W 3'd2

`define BUS_BURST_INCR 2'b01

`define BUS_RESP_OKAY 2'b00

`endif

/* bus_pkg.sv */
package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;      // byte enables within one word
  typedef logic [63:0] beat_t;
  typedef logic [7:0]  beat_strb_t;

  typedef enum logic [2:0] {
    req_none  = 3'd0,
    req_fetch = 3'd1,
    req_load  = 3'd2,
    req_store = 3'd3,
    req_timer = 3'd4  // load that hits mtime
  } req_kind_t;

  typedef struct packed {
    req_kind_t kind;
    addr_t     addr;
    word_t     wdata;
    strb_t     strb;
  } bus_req_t;

  typedef enum logic [2:0] {
    st_idle  = 3'd0,
    st_raddr = 3'd1,
    st_rdata = 3'd2,
    st_waddr = 3'd3,   // aw and w together
    st_wresp = 3'd4
  } bus_state_t;

endpackage

/* bus_xfer_fsm.sv */
`timescale 1ns/1ns
`include "bus_consts.svh"

module bus_xfer_fsm (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req_i,
  output logic              fsm_idle_o,
  output bus_pkg::bus_req_t cur_req_o,
  output logic              arvalid_o,
  input  logic              arready_i,
  input  logic              rvalid_i,
  output logic              rready_o,
  input  logic [1:0]        rresp_i,
  output logic              awvalid_o,
  input  logic              awready_i,
  output logic              wvalid_o,
  input  logic              wready_i,
  output logic              wlast_o,
  input  logic              bvalid_i,
  output logic              bready_o,
  input  logic [1:0]        bresp_i,
  output logic              timer_rd_o,
  input  logic              timer_rvalid_i,
  output logic              done_o
);
  import bus_pkg::*;

  bus_state_t state_q;
  bus_req_t   req_q;
  logic       aw_done_q;
  logic       w_done_q;
  logic       is_timer;
  logic       aw_ok;
  logic       w_ok;

  assign is_timer = (req_q.kind == req_timer);
  assign aw_ok    = aw_done_q | awready_i;
  assign w_ok     = w_done_q | wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= st_idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        st_idle:
          if (req_i.kind != req_none)
          begin
            state_q   <= (req_i.kind == req_store) ? st_waddr : st_raddr;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
        st_raddr:
          if (is_timer | arready_i)
            state_q <= st_rdata;  // timer strobe goes out here
        st_rdata:
          if (is_timer ? timer_rvalid_i : rvalid_i)
            state_q <= st_idle;
        st_waddr:
          if (aw_ok & w_ok)
            state_q <= st_wresp;
          else
          begin
            aw_done_q <= aw_ok;
            w_done_q  <= w_ok;
          end
        st_wresp:
          if (bvalid_i)
            state_q <= st_idle;
        default:
          state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == st_idle)
      req_q <= req_i;
  end

  assign fsm_idle_o = (state_q == st_idle);
  assign cur_req_o  = req_q;
  assign arvalid_o  = (state_q == st_raddr) & ~is_timer;
  assign rready_o   = (state_q == st_rdata) & ~is_timer;
  assign awvalid_o  = (state_q == st_waddr) & ~aw_done_q;
  assign wvalid_o   = (state_q == st_waddr) & ~w_done_q;
  assign wlast_o    = wvalid_o;  // single beat
  assign bready_o   = (state_q == st_wresp);
  assign timer_rd_o = (state_q == st_raddr) & is_timer;

  always_comb
  begin
    case (state_q)
      st_rdata: done_o = is_timer ? timer_rvalid_i : rvalid_i;
      st_wresp: done_o = bvalid_i;
      default:  done_o = 1'b0;
    endcase
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(cur_req_o.addr))
    else $error("arvalid dropped before arready");

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_o && !awready_i |=> awvalid_o && $stable(cur_req_o.addr))
    else $error("awvalid dropped before awready");

  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    rvalid_i && rready_o |-> rresp_i == `BUS_RESP_OKAY)
    else $error("read response not okay");

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    bvalid_i && bready_o |-> bresp_i == `BUS_RESP_OKAY)
    else $error("write response not okay");

endmodule

/* clint_timer.sv */
`timescale 1ns/1ns

module clint_timer (
  input  logic           clk,
  input  logic           rst,
  input  logic           rd_i,
  input  logic           rd_hi_i,
  output bus_pkg::word_t rdata_o,
  output logic           rvalid_o
);
  import bus_pkg::*;

  logic [63:0] mtime_q;
  word_t       rdata_q;
  logic        rvalid_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= 64'd0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_q + 64'd1;
      rvalid_q <= rd_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_q <= rd_hi_i ? mtime_q[63:32] : mtime_q[31:0];
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

/* core_bus.f */
+incdir+.
bus_pkg.sv
mem_req_arbiter.sv
bus_xfer_fsm.sv
axi_lane_adapter.sv
clint_timer.sv
core_bus.sv
tb_axi_mem.sv
tb_core_bus.sv

/* core_bus.sv */
`timescale 1ns/1ns
`include "bus_consts.svh"

module core_bus (
  input  logic                clk,
  input  logic                rst,
  input  logic                ifu_arvalid_i,
  input  bus_pkg::addr_t      ifu_araddr_i,
  output logic                ifu_rvalid_o,
  output bus_pkg::word_t      ifu_rdata_o,
  input  logic                lsu_arvalid_i,
  input  bus_pkg::addr_t      lsu_araddr_i,
  input  bus_pkg::strb_t      lsu_rstrb_i,
  output logic                lsu_rvalid_o,
  output bus_pkg::word_t      lsu_rdata_o,
  input  logic                lsu_awvalid_i,
  input  bus_pkg::addr_t      lsu_awaddr_i,
  input  bus_pkg::word_t      lsu_wdata_i,
  input  bus_pkg::strb_t      lsu_wstrb_i,
  output logic                lsu_wready_o,
  output bus_pkg::addr_t      io_master_araddr,
  output logic [2:0]          io_master_arsize,
  output logic [7:0]          io_master_arlen,
  output logic [1:0]          io_master_arburst,
  output logic [3:0]          io_master_arid,
  output logic                io_master_arvalid,
  input  logic                io_master_arready,
  input  bus_pkg::beat_t      io_master_rdata,
  input  logic [1:0]          io_master_rresp,
  input  logic                io_master_rvalid,
  output logic                io_master_rready,
  output bus_pkg::addr_t      io_master_awaddr,
  output logic [2:0]          io_master_awsize,
  output logic [7:0]          io_master_awlen,
  output logic [1:0]          io_master_awburst,
  output logic [3:0]          io_master_awid,
  output logic                io_master_awvalid,
  input  logic                io_master_awready,
  output bus_pkg::beat_t      io_master_wdata,
  output bus_pkg::beat_strb_t io_master_wstrb,
  output logic                io_master_wlast,
  output logic                io_master_wvalid,
  input  logic                io_master_wready,
  input  logic [1:0]          io_master_bresp,
  input  logic                io_master_bvalid,
  output logic                io_master_bready
);
  import bus_pkg::*;

  bus_req_t req;
  bus_req_t cur_req;
  logic     fsm_idle;
  logic     done;
  word_t    lane_rdata;
  word_t    done_data;
  logic     timer_rd;
  logic     timer_rvalid;
  word_t    timer_rdata;

  // single beat, id 0
  assign io_master_arlen   = 8'd0;
  assign io_master_awlen   = 8'd0;
  assign io_master_arburst = `BUS_BURST_INCR;
  assign io_master_awburst = `BUS_BURST_INCR;
  assign io_master_arid    = 4'd0;
  assign io_master_awid    = 4'd0;

  assign done_data = timer_rvalid ? timer_rdata : lane_rdata;

  mem_req_arbiter arb_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .fsm_idle_i    (fsm_idle),
    .done_i        (done),
    .done_data_i   (done_data),
    .req_o         (req),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_rdata_o   (ifu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_wready_o  (lsu_wready_o)
  );

  bus_xfer_fsm fsm_i (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req),
    .fsm_idle_o     (fsm_idle),
    .cur_req_o      (cur_req),
    .arvalid_o      (io_master_arvalid),
    .arready_i      (io_master_arready),
    .rvalid_i       (io_master_rvalid),
    .rready_o       (io_master_rready),
    .rresp_i        (io_master_rresp),
    .awvalid_o      (io_master_awvalid),
    .awready_i      (io_master_awready),
    .wvalid_o       (io_master_wvalid),
    .wready_i       (io_master_wready),
    .wlast_o        (io_master_wlast),
    .bvalid_i       (io_master_bvalid),
    .bready_o       (io_master_bready),
    .bresp_i        (io_master_bresp),
    .timer_rd_o     (timer_rd),
    .timer_rvalid_i (timer_rvalid),
    .done_o         (done)
  );

  axi_lane_adapter lane_i (
    .cur_req_i (cur_req),
    .araddr_o  (io_master_araddr),
    .arsize_o  (io_master_arsize),
    .awaddr_o  (io_master_awaddr),
    .awsize_o  (io_master_awsize),
    .wdata_o   (io_master_wdata),
    .wstrb_o   (io_master_wstrb),
    .rdata_i   (io_master_rdata),
    .rdata_o   (lane_rdata)
  );

  // bit 2 tells the mtime halves apart
  clint_timer clint_i (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (timer_rd),
    .rd_hi_i  (cur_req.addr[2]),
    .rdata_o  (timer_rdata),
    .rvalid_o (timer_rvalid)
  );

endmodule

/* mem_req_arbiter.sv */
`timescale 1ns/1ns
`include "bus_consts.svh"

module mem_req_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  logic              ifu_arvalid_i,
  input  bus_pkg::addr_t    ifu_araddr_i,
  input  logic              lsu_arvalid_i,
  input  bus_pkg::addr_t    lsu_araddr_i,
  input  bus_pkg::strb_t    lsu_rstrb_i,
  input  logic              lsu_awvalid_i,
  input  bus_pkg::addr_t    lsu_awaddr_i,
  input  bus_pkg::word_t    lsu_wdata_i,
  input  bus_pkg::strb_t    lsu_wstrb_i,
  input  logic              fsm_idle_i,
  input  logic              done_i,
  input  bus_pkg::word_t    done_data_i,
  output bus_pkg::bus_req_t req_o,
  output logic              ifu_rvalid_o,
  output bus_pkg::word_t    ifu_rdata_o,
  output logic              lsu_rvalid_o,
  output bus_pkg::word_t    lsu_rdata_o,
  output logic              lsu_wready_o
);
  import bus_pkg::*;

  req_kind_t owner_q;
  logic      mask_q;    // requester still high right after its pulse
  logic      grant_ok;
  logic      timer_hit;

  assign grant_ok  = fsm_idle_i & ~mask_q;
  assign timer_hit = (lsu_araddr_i == `BUS_RTC_ADDR) | (lsu_araddr_i == `BUS_RTC_ADDR_UP);

  // store > load > fetch
  always_comb
  begin
    req_o = '0;
    if (grant_ok)
    begin
      if (lsu_awvalid_i)
      begin
        req_o.kind  = req_store;
        req_o.addr  = lsu_awaddr_i;
        req_o.wdata = lsu_wdata_i;
        req_o.strb  = lsu_wstrb_i;
      end
      else if (lsu_arvalid_i)
      begin
        req_o.kind = timer_hit ? req_timer : req_load;
        req_o.addr = lsu_araddr_i;
        req_o.strb = lsu_rstrb_i;
      end
      else if (ifu_arvalid_i)
      begin
        req_o.kind = req_fetch;
        req_o.addr = ifu_araddr_i;
        req_o.strb = 4'hf;  // always a full word
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner_q <= req_none;
      mask_q  <= 1'b0;
    end
    else
    begin
      mask_q <= done_i;
      if (req_o.kind != req_none)
        owner_q <= req_o.kind;  // fsm takes it this cycle
    end
  end

  assign ifu_rvalid_o = done_i & (owner_q == req_fetch);
  assign lsu_rvalid_o = done_i & ((owner_q == req_load) | (owner_q == req_timer));
  assign lsu_wready_o = done_i & (owner_q == req_store);
  assign ifu_rdata_o  = done_data_i;
  assign lsu_rdata_o  = done_data_i;

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ns

module tb_axi_mem (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [63:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i
);
  logic [31:0] mem [256];  // 1 KiB, word per entry
  logic [31:0] rng_q;
  logic [31:0] raddr_q;
  logic [31:0] awaddr_q;
  logic [63:0] wdata_q;
  logic [7:0]  wstrb_q;
  logic [1:0]  ar_cnt;
  logic [1:0]  r_cnt;
  logic [1:0]  aw_cnt;
  logic [1:0]  w_cnt;
  logic [1:0]  b_cnt;
  logic        r_pend;
  logic        aw_got;
  logic        w_got;
  logic        b_pend;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                              input logic [3:0] be);
    logic [31:0] res;
    int          b;
    res = old;
    for (b = 0; b < 4; b++)
      if (be[b])
        res[8*b +: 8] = nw[8*b +: 8];
    return res;
  endfunction

  initial
  begin
    int i;
    for (i = 0; i < 256; i++)
      mem[i] = {22'd0, i[7:0], 2'b00} ^ 32'h5a5a_0000;
  end

  assign rresp_o = 2'b00;
  assign bresp_o = 2'b00;

  always @(posedge clk)
  begin
    if (rst)
    begin
      rng_q     <= 32'hcf05_1bf6;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      r_pend    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_pend    <= 1'b0;
      ar_cnt    <= 2'd0;
      aw_cnt    <= 2'd0;
      w_cnt     <= 2'd0;
    end
    else
    begin
      rng_q <= xorshift32(rng_q);
      if (arvalid_i && arready_o)
      begin
        arready_o <= 1'b0;
        raddr_q   <= araddr_i;
        r_pend    <= 1'b1;
        r_cnt     <= rng_q[3:2];
        ar_cnt    <= rng_q[1:0];
      end
      else if (arvalid_i && !r_pend)
      begin
        if (ar_cnt == 2'd0)
          arready_o <= 1'b1;
        else
          ar_cnt <= ar_cnt - 2'd1;
      end
      if (rvalid_o && rready_i)
      begin
        rvalid_o <= 1'b0;
        r_pend   <= 1'b0;
      end
      else if (r_pend && !rvalid_o)
      begin
        if (r_cnt == 2'd0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= {mem[{raddr_q[9:3], 1'b1}], mem[{raddr_q[9:3], 1'b0}]};
        end
        else
          r_cnt <= r_cnt - 2'd1;
      end
      if (awvalid_i && awready_o)
      begin
        awready_o <= 1'b0;
        awaddr_q  <= awaddr_i;
        aw_got    <= 1'b1;
        aw_cnt    <= rng_q[5:4];
      end
      else if (awvalid_i && !aw_got)
      begin
        if (aw_cnt == 2'd0)
          awready_o <= 1'b1;
        else
          aw_cnt <= aw_cnt - 2'd1;
      end
      if (wvalid_i && wready_o)
      begin
        wready_o <= 1'b0;
        wdata_q  <= wdata_i;
        wstrb_q  <= wstrb_i;
        w_got    <= 1'b1;
        w_cnt    <= rng_q[7:6];
      end
      else if (wvalid_i && !w_got)
      begin
        if (w_cnt == 2'd0)
          wready_o <= 1'b1;
        else
          w_cnt <= w_cnt - 2'd1;
      end
      // both halves of the beat, strobes pick the bytes
      if (aw_got && w_got && !b_pend)
      begin
        mem[{awaddr_q[9:3], 1'b0}] <= merge_bytes(mem[{awaddr_q[9:3], 1'b0}],
                                                  wdata_q[31:0], wstrb_q[3:0]);
        mem[{awaddr_q[9:3], 1'b1}] <= merge_bytes(mem[{awaddr_q[9:3], 1'b1}],
                                                  wdata_q[63:32], wstrb_q[7:4]);
        b_pend <= 1'b1;
        b_cnt  <= rng_q[9:8];
      end
      if (bvalid_o && bready_i)
      begin
        bvalid_o <= 1'b0;
        b_pend   <= 1'b0;
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
      end
      else if (b_pend && !bvalid_o)
      begin
        if (b_cnt == 2'd0)
          bvalid_o <= 1'b1;
        else
          b_cnt <= b_cnt - 2'd1;
      end
    end
  end

endmodule

/* tb_core_bus.sv */
`timescale 1ns/1ns
`include "bus_consts.svh"

module tb_core_bus;
  import bus_pkg::*;

  localparam int max_cycles = 4000;  // about twice the longest run at 3-cycle delays
  localparam int kind_fetch = 0;
  localparam int kind_load  = 1;
  localparam int kind_store = 2;

  logic       clk = 1'b0;
  logic       rst;
  logic       ifu_arvalid_i;
  addr_t      ifu_araddr_i;
  logic       ifu_rvalid_o;
  word_t      ifu_rdata_o;
  logic       lsu_arvalid_i;
  addr_t      lsu_araddr_i;
  strb_t      lsu_rstrb_i;
  logic       lsu_rvalid_o;
  word_t      lsu_rdata_o;
  logic       lsu_awvalid_i;
  addr_t      lsu_awaddr_i;
  word_t      lsu_wdata_i;
  strb_t      lsu_wstrb_i;
  logic       lsu_wready_o;
  addr_t      io_master_araddr, io_master_awaddr;
  logic [2:0] io_master_arsize, io_master_awsize;
  logic [7:0] io_master_arlen, io_master_awlen;
  logic [1:0] io_master_arburst, io_master_awburst;
  logic [3:0] io_master_arid, io_master_awid;
  logic       io_master_arvalid, io_master_arready;
  beat_t      io_master_rdata, io_master_wdata;
  logic [1:0] io_master_rresp, io_master_bresp;
  logic       io_master_rvalid, io_master_rready;
  logic       io_master_awvalid, io_master_awready;
  beat_strb_t io_master_wstrb;
  logic       io_master_wlast, io_master_wvalid, io_master_wready;
  logic       io_master_bvalid, io_master_bready;

  word_t model [256];
  string cur_test = "reset";
  logic [31:0] rnd = 32'hcf05_1bf6;
  int cycle_cnt = 0;
  int ar_cycles = 0;
  int ifu_pulses = 0;
  int lsu_rpulses = 0;
  int lsu_wpulses = 0;
  int exp_ifu = 0;
  int exp_lsu_r = 0;
  int exp_lsu_w = 0;

  core_bus core_bus_i (.*);

  tb_axi_mem mem_i (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (io_master_araddr),
    .arvalid_i (io_master_arvalid),
    .arready_o (io_master_arready),
    .rdata_o   (io_master_rdata),
    .rresp_o   (io_master_rresp),
    .rvalid_o  (io_master_rvalid),
    .rready_i  (io_master_rready),
    .awaddr_i  (io_master_awaddr),
    .awvalid_i (io_master_awvalid),
    .awready_o (io_master_awready),
    .wdata_i   (io_master_wdata),
    .wstrb_i   (io_master_wstrb),
    .wvalid_i  (io_master_wvalid),
    .wready_o  (io_master_wready),
    .bresp_o   (io_master_bresp),
    .bvalid_o  (io_master_bvalid),
    .bready_i  (io_master_bready)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, name, exp, act);
      abort_run("value mismatch");
    end
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [2:0] size_of(input strb_t s);
    case (s)
      4'h3:    return `BUS_SIZE_H;
      4'hf:    return `BUS_SIZE_W;
      default: return `BUS_SIZE_B;
    endcase
  endfunction

  function automatic word_t expected_word(input addr_t a);
    return model[a[9:2]];
  endfunction

  // shifted bytes land inside the addressed word
  function automatic void apply_store(input addr_t a, input word_t d, input strb_t s);
    word_t sh_d;
    strb_t sh_s;
    int    b;
    sh_d = d << {a[1:0], 3'b000};
    sh_s = s << a[1:0];
    for (b = 0; b < 4; b++)
      if (sh_s[b])
        model[a[9:2]][8*b +: 8] = sh_d[8*b +: 8];
  endfunction

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles)
      abort_run("timeout: a request never completed");
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (ifu_rvalid_o)
        ifu_pulses++;
      if (lsu_rvalid_o)
        lsu_rpulses++;
      if (lsu_wready_o)
        lsu_wpulses++;
      if (io_master_arvalid)
      begin
        ar_cycles++;
        check_value("ar fields", 32'({8'd0, 2'b01, 4'd0, `BUS_SIZE_W}),
          32'({io_master_arlen, io_master_arburst, io_master_arid, io_master_arsize}));
        check_value("araddr", lsu_arvalid_i ? lsu_araddr_i : ifu_araddr_i,
          io_master_araddr);
      end
      if (io_master_awvalid)
      begin
        check_value("aw fields", 32'({8'd0, 2'b01, 4'd0, size_of(lsu_wstrb_i)}),
          32'({io_master_awlen, io_master_awburst, io_master_awid, io_master_awsize}));
        check_value("awaddr", lsu_awaddr_i, io_master_awaddr);
      end
      if (io_master_wvalid)
        check_value("wlast", 32'd1, 32'(io_master_wlast));
    end
  end

  // holds the request until its pulse
  task automatic run_req(input int kind, input addr_t addr, input word_t wdata,
                         input strb_t strb, output word_t rdata, output int lat);
    logic got;
    got   = 1'b0;
    lat   = 0;  // negedges since the drive
    rdata = '0;
    @(posedge clk);
    #2;
    case (kind)
      kind_fetch:
      begin
        ifu_arvalid_i = 1'b1;
        ifu_araddr_i  = addr;
        exp_ifu++;
      end
      kind_load:
      begin
        lsu_arvalid_i = 1'b1;
        lsu_araddr_i  = addr;
        lsu_rstrb_i   = strb;
        exp_lsu_r++;
      end
      default:
      begin
        lsu_awvalid_i = 1'b1;
        lsu_awaddr_i  = addr;
        lsu_wdata_i   = wdata;
        lsu_wstrb_i   = strb;
        exp_lsu_w++;
      end
    endcase
    while (!got)
    begin
      @(negedge clk);
      lat++;
      if (kind == kind_fetch && ifu_rvalid_o)
      begin
        got   = 1'b1;
        rdata = ifu_rdata_o;
      end
      if (kind == kind_load && lsu_rvalid_o)
      begin
        got   = 1'b1;
        rdata = lsu_rdata_o;
      end
      if (kind == kind_store && lsu_wready_o)
        got = 1'b1;
    end
    @(posedge clk);
    #2;
    ifu_arvalid_i = 1'b0;
    lsu_arvalid_i = 1'b0;
    lsu_awvalid_i = 1'b0;
  endtask

  task automatic load_check(input string name, input int kind, input addr_t addr);
    word_t d;
    int    lat;
    run_req(kind, addr, '0, 4'hf, d, lat);
    check_value(name, expected_word(addr), d);
  endtask

  task automatic do_store(input addr_t addr, input word_t data, input strb_t strb);
    word_t d;
    int    lat;
    run_req(kind_store, addr, data, strb, d, lat);
    apply_store(addr, data, strb);
  endtask

  task automatic fetch_lanes();
    cur_test = "fetch";
    load_check("low lane", kind_fetch, 32'h0000_0020);
    load_check("high lane", kind_fetch, 32'h0000_0024);
  endtask

  task automatic load_before_fetch();
    word_t ld;
    word_t fd;
    logic  lsu_done;
    logic  ifu_done;
    cur_test = "priority";
    lsu_done = 1'b0;
    ifu_done = 1'b0;
    ld       = '0;
    fd       = '0;
    @(posedge clk);
    #2;
    ifu_arvalid_i = 1'b1;
    ifu_araddr_i  = 32'h0000_0030;
    lsu_arvalid_i = 1'b1;
    lsu_araddr_i  = 32'h0000_0054;
    lsu_rstrb_i   = 4'hf;
    exp_ifu++;
    exp_lsu_r++;
    while (!ifu_done)
    begin
      @(negedge clk);
      if (ifu_rvalid_o)
      begin
        ifu_done = 1'b1;
        fd       = ifu_rdata_o;
        if (!lsu_done)
          abort_run("fetch completed before the pending load");
      end
      if (lsu_rvalid_o)
      begin
        lsu_done = 1'b1;
        ld       = lsu_rdata_o;
      end
      @(posedge clk);
      #2;
      if (lsu_done)
        lsu_arvalid_i = 1'b0;
    end
    ifu_arvalid_i = 1'b0;
    check_value("load data", expected_word(32'h0000_0054), ld);
    check_value("fetch data", expected_word(32'h0000_0030), fd);
  endtask

  task automatic store_merge();
    cur_test = "store";
    do_store(32'h0000_0040, 32'h1122_3344, 4'hf);
    do_store(32'h0000_0046, 32'h0000_abcd, 4'h3);
    do_store(32'h0000_004b, 32'h0000_00ef, 4'h1);
    load_check("word 0x40", kind_load, 32'h0000_0040);
    load_check("word 0x44", kind_load, 32'h0000_0044);
    load_check("word 0x48", kind_load, 32'h0000_0048);
  endtask

  task automatic timer_reads();
    word_t t0;
    word_t t1;
    word_t hi;
    int    lat;
    int    ar0;
    cur_test = "timer";
    ar0 = ar_cycles;
    run_req(kind_load, `BUS_RTC_ADDR, '0, 4'hf, t0, lat);
    check_value("latency low 1", 2, lat - 1);
    run_req(kind_load, `BUS_RTC_ADDR, '0, 4'hf, t1, lat);
    check_value("latency low 2", 2, lat - 1);
    if (t1 <= t0)
      abort_run("timer: mtime low half did not increase between two reads");
    run_req(kind_load, `BUS_RTC_ADDR_UP, '0, 4'hf, hi, lat);
    check_value("latency high", 2, lat - 1);
    check_value("mtime high half", 32'd0, hi);
    check_value("arvalid cycles", ar0, ar_cycles);
  endtask

  task automatic mixed_traffic();
    addr_t addr;
    word_t data;
    int    n;
    cur_test = "backpressure";
    for (n = 0; n < 40; n++)
    begin
      rnd  = next_rand(rnd);
      addr = {22'd0, 2'b10, rnd[9:4], 2'b00};  // words 0x200..0x2fc
      case (rnd[1:0])
        2'd0: load_check("mixed fetch", kind_fetch, addr);
        2'd1: load_check("mixed load", kind_load, addr);
        default:
        begin
          data = next_rand(rnd);
          case (rnd[11:10])
            2'd0:    do_store(addr, data, 4'hf);
            2'd1:    do_store({addr[31:2], rnd[12], 1'b0}, data, 4'h3);
            default: do_store({addr[31:2], rnd[13:12]}, data, 4'h1);
          endcase
        end
      endcase
    end
    for (n = 0; n < 64; n++)
      load_check("sweep", kind_fetch, {22'd0, 2'b10, n[5:0], 2'b00});
  endtask

  initial
  begin
    int i;
    rst           = 1'b1;
    ifu_arvalid_i = 1'b0;
    ifu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_rstrb_i   = '0;
    lsu_awvalid_i = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    for (i = 0; i < 256; i++)
      model[i] = {22'd0, i[7:0], 2'b00} ^ 32'h5a5a_0000;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_value("axi valids", 32'd0, 32'({io_master_arvalid, io_master_awvalid,
      io_master_wvalid, io_master_rready, io_master_bready}));
    check_value("pulses", 32'd0, 32'({ifu_rvalid_o, lsu_rvalid_o, lsu_wready_o}));
    fetch_lanes();
    load_before_fetch();
    store_merge();
    timer_reads();
    mixed_traffic();
    cur_test = "pulse count";
    check_value("fetch", exp_ifu, ifu_pulses);
    check_value("load", exp_lsu_r, lsu_rpulses);
    check_value("store", exp_lsu_w, lsu_wpulses);
    $display(">>> PASS");
    $finish;
  end

endmodule
